/* bench/dac_frame_monitor.sv */
module dac_frame_monitor
    import dac_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  dac_cs_n,
    input  logic  dac_sclk,
    input  logic  dac_din,
    input  logic  dac_ldac_n,
    input  logic  busy,

    // One pulse per frame, the values below hold until the next frame
    output logic  frame_done,
    output code_t frame_code,
    output int    cs_cycles,
    output int    sclk_edges,
    output int    gap_cycles,
    output int    ldac_cycles,
    output logic  frame_busy_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    code_t shift_bits;
    int    cs_cnt;
    int    edge_cnt;
    int    gap_cnt;
    int    low_cnt;
    logic  in_frame;
    logic  prev_sclk;
    logic  busy_dropped;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_done    <= 1'b0;
            frame_code    <= '0;
            cs_cycles     <= 0;
            sclk_edges    <= 0;
            gap_cycles    <= 0;
            ldac_cycles   <= 0;
            frame_busy_ok <= 1'b1;
            shift_bits    <= '0;
            cs_cnt        <= 0;
            edge_cnt      <= 0;
            gap_cnt       <= 0;
            low_cnt       <= 0;
            in_frame      <= 1'b0;
            prev_sclk     <= 1'b0;
            busy_dropped  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            prev_sclk  <= dac_sclk;
            if (!dac_cs_n && !in_frame) begin
                // Chip select just fell, a new frame starts
                in_frame     <= 1'b1;
                cs_cnt       <= 1;
                edge_cnt     <= 0;
                gap_cnt      <= 0;
                low_cnt      <= 0;
                shift_bits   <= '0;
                busy_dropped <= !busy;
            end else if (!dac_cs_n) begin
                cs_cnt       <= cs_cnt + 1;
                busy_dropped <= busy_dropped || !busy;
                // DAC samples on the rising edge of sclk
                if (dac_sclk && !prev_sclk) begin
                    shift_bits <= {shift_bits[SAMPLE_BITS-2:0], dac_din};
                    edge_cnt   <= edge_cnt + 1;
                end
            end else if (in_frame) begin
                if (!dac_ldac_n) begin
                    low_cnt      <= low_cnt + 1;
                    busy_dropped <= busy_dropped || !busy;
                end else if (low_cnt == 0) begin
                    gap_cnt      <= gap_cnt + 1;
                    busy_dropped <= busy_dropped || !busy;
                end else begin
                    // LDAC back high, conversion complete
                    in_frame      <= 1'b0;
                    frame_done    <= 1'b1;
                    frame_code    <= shift_bits;
                    cs_cycles     <= cs_cnt;
                    sclk_edges    <= edge_cnt;
                    gap_cycles    <= gap_cnt;
                    ldac_cycles   <= low_cnt;
                    frame_busy_ok <= !busy_dropped;
                end
            end
        end
    end

endmodule

/* bench/tb_pmod_dac_stream.sv */
module tb_pmod_dac_stream
    import dac_types_pkg::*;
    import dac_spi_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESOLUTION = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int SCLK_DIV   = 4;
    localparam int CLK_PERIOD = 10;

    // Expected frame shape in clk cycles
    localparam int CS_LOW_CYCLES = 2 * RESOLUTION * SCLK_DIV;
    localparam int GAP_CYCLES    = LDAC_GAP_HALVES * SCLK_DIV;
    localparam int PULSE_CYCLES  = LDAC_WIDTH_HALVES * SCLK_DIV;

    localparam int ORDER_COUNT   = 40;
    localparam int PHASE_COUNT   = 5;
    localparam int PHASE_LEN     = 12;
    localparam int BURST_COUNT   = 30;
    localparam int TOTAL_SAMPLES = ORDER_COUNT + PHASE_COUNT * PHASE_LEN + BURST_COUNT;
    localparam int WATCHDOG_NS   = TOTAL_SAMPLES
        * (CS_LOW_CYCLES + GAP_CYCLES + PULSE_CYCLES + 10) * 2 * CLK_PERIOD;

    // Longer than the idle cycles between two queued frames
    localparam int DRAIN_IDLE_CYCLES = 8;

    logic    clk;
    logic    rst;
    gain_t   gain;
    logic    s_valid;
    sample_t s_data;
    logic    s_ready;
    logic    busy;
    logic    dac_cs_n;
    logic    dac_sclk;
    logic    dac_din;
    logic    dac_ldac_n;

    logic    frame_done;
    code_t   frame_code;
    int      cs_cycles;
    int      sclk_edges;
    int      gap_cycles;
    int      ldac_cycles;
    logic    frame_busy_ok;

    code_t   expected_q[$];
    int      accepted_cnt = 0;
    int      frame_cnt    = 0;

    pmod_dac_stream #(
        .RESOLUTION (RESOLUTION),
        .FIFO_DEPTH (FIFO_DEPTH),
        .SCLK_DIV   (SCLK_DIV)
    ) i_pmod_dac_stream (
        .clk        (clk),
        .rst        (rst),
        .gain       (gain),
        .s_valid    (s_valid),
        .s_data     (s_data),
        .s_ready    (s_ready),
        .busy       (busy),
        .dac_cs_n   (dac_cs_n),
        .dac_sclk   (dac_sclk),
        .dac_din    (dac_din),
        .dac_ldac_n (dac_ldac_n)
    );

    dac_frame_monitor i_dac_frame_monitor (
        .clk           (clk),
        .rst           (rst),
        .dac_cs_n      (dac_cs_n),
        .dac_sclk      (dac_sclk),
        .dac_din       (dac_din),
        .dac_ldac_n    (dac_ldac_n),
        .busy          (busy),
        .frame_done    (frame_done),
        .frame_code    (frame_code),
        .cs_cycles     (cs_cycles),
        .sclk_edges    (sclk_edges),
        .gap_cycles    (gap_cycles),
        .ldac_cycles   (ldac_cycles),
        .frame_busy_ok (frame_busy_ok)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Scale by gain/64 with floor, clamp, then shift to offset binary
    function automatic code_t expected_code(input sample_t sample, input gain_t g);
        longint prod;
        longint quot;
        longint divisor;
        divisor = longint'(1) << GAIN_FRAC_BITS;
        prod    = longint'(sample) * longint'(g);
        quot    = prod / divisor;
        if (prod < 0 && (prod % divisor) != 0) begin
            quot = quot - 1;
        end
        if (quot > 32767) begin
            quot = 32767;
        end else if (quot < -32768) begin
            quot = -32768;
        end
        return code_t'(quot + 32768);
    endfunction

    // Extreme values mixed into the random samples
    function automatic sample_t phase_sample(input int idx);
        logic [31:0] rnd;
        rnd = $urandom();
        case (idx)
            0:       return 16'h8000;
            2:       return 16'h7FFF;
            4:       return 16'hFFFF;
            6:       return 16'h0001;
            8:       return 16'h0000;
            default: return rnd[15:0];
        endcase
    endfunction

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (expected !== actual) begin
            $display("Error: time %0t: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle_outputs(input string when);
        check_value(1, dac_cs_n, {"dac_cs_n ", when});
        check_value(1, dac_ldac_n, {"dac_ldac_n ", when});
        check_value(0, dac_sclk, {"dac_sclk ", when});
        check_value(0, busy, {"busy ", when});
        check_value(1, s_ready, {"s_ready ", when});
    endtask

    task automatic send_sample(input sample_t data, input int gap);
        logic took;
        s_valid = 1'b1;
        s_data  = data;
        do begin
            took = s_ready;
            step();
        end while (!took);
        s_valid = 1'b0;
        repeat (gap) step();
    endtask

    // The pipeline is empty once busy stays low longer than a frame gap
    task automatic drain_pipeline();
        int idle_cycles;
        idle_cycles = 0;
        while (idle_cycles < DRAIN_IDLE_CYCLES) begin
            step();
            if (busy) begin
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
        end
    endtask

    // Model queue fed at each transfer and compared at each finished frame
    always @(posedge clk) begin
        if (!rst && s_valid && s_ready) begin
            expected_q.push_back(expected_code(s_data, gain));
            accepted_cnt++;
        end
        if (frame_done) begin
            check_value(1, expected_q.size() != 0, "frame arrived with a sample pending");
            check_value(32'(expected_q.pop_front()), 32'(frame_code), "frame code");
            check_value(CS_LOW_CYCLES, cs_cycles, "chip select low cycles");
            check_value(RESOLUTION, sclk_edges, "sclk rising edges");
            check_value(GAP_CYCLES, gap_cycles, "chip select to LDAC gap");
            check_value(PULSE_CYCLES, ldac_cycles, "LDAC pulse width");
            check_value(1, frame_busy_ok, "busy held through the frame");
            frame_cnt++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] rnd;
        gain_t       phase_gain;
        int          stalled_at;
        int          burst_accepted;
        logic        took;

        void'($urandom(32'h3a39));
        rst     = 1'b1;
        gain    = 8'd64;
        s_valid = 1'b0;
        s_data  = '0;

        step();
        check_idle_outputs("during reset");
        repeat (2) step();
        rst = 1'b0;
        step();
        check_idle_outputs("after reset");

        // Unity gain keeps the sample and only flips the MSB
        for (int i = 0; i < ORDER_COUNT; i++) begin
            rnd = $urandom();
            send_sample(rnd[15:0], $urandom_range(5, 0));
        end
        drain_pipeline();

        // Gain only changes while the pipeline is empty
        for (int p = 0; p < PHASE_COUNT; p++) begin
            rnd = $urandom();
            case (p)
                0:       phase_gain = 8'd0;
                1:       phase_gain = 8'd64;
                2:       phase_gain = 8'd255;
                default: phase_gain = rnd[7:0];
            endcase
            gain = phase_gain;
            for (int i = 0; i < PHASE_LEN; i++) begin
                send_sample(phase_sample(i), $urandom_range(3, 0));
            end
            drain_pipeline();
        end

        // Burst with valid held high until the FIFO pushes back
        stalled_at     = -1;
        burst_accepted = 0;
        s_valid        = 1'b1;
        rnd            = $urandom();
        s_data         = rnd[15:0];
        while (burst_accepted < BURST_COUNT) begin
            took = s_ready;
            if (!took && stalled_at < 0) begin
                stalled_at = burst_accepted;
            end
            step();
            if (took) begin
                burst_accepted++;
                rnd    = $urandom();
                s_data = rnd[15:0];
            end
        end
        s_valid = 1'b0;
        // FIFO full plus one in the formatter and one being serialized
        check_value(FIFO_DEPTH + 2, stalled_at, "samples pending when s_ready fell");
        drain_pipeline();

        check_value(accepted_cnt, frame_cnt, "frame count against accepted count");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* pmod_dac_stream.f */
source/dac_types_pkg.sv
source/dac_spi_pkg.sv
source/sample_fifo.sv
source/sample_formatter.sv
source/dac_spi_serializer.sv
source/pmod_dac_stream.sv
bench/dac_frame_monitor.sv
bench/tb_pmod_dac_stream.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_pmod_dac_stream -f pmod_dac_stream.f \
    || { echo "Build failed"; exit 1; }

./obj_dir/Vtb_pmod_dac_stream 2>&1 | tee sim.log

grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

/* source/dac_spi_pkg.sv */
package dac_spi_pkg;

    // Serializer states, one SPI frame then the LDAC strobe
    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT,
        DESELECT,
        LOAD
    } spi_state_t;

    // Half serial-clock periods from chip select high to LDAC low
    localparam int LDAC_GAP_HALVES = 2;

    // Width of the LDAC low pulse in half periods
    localparam int LDAC_WIDTH_HALVES = 2;

endpackage

/* source/dac_spi_serializer.sv */
module dac_spi_serializer
    import dac_types_pkg::*;
    import dac_spi_pkg::*;
#(
    parameter int RESOLUTION = 16,
    parameter int SCLK_DIV   = 4
) (
    input  logic  clk,
    input  logic  rst,

    // Code stream from the formatter
    input  logic  code_valid,
    input  code_t code,
    output logic  code_ready,
    output logic  busy,

    // DAC pins, SPI mode 0
    output logic  dac_cs_n,
    output logic  dac_sclk,
    output logic  dac_din,
    output logic  dac_ldac_n
);

    localparam int DIV_W = (SCLK_DIV > 2) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(RESOLUTION) + 1;

    spi_state_t         state;
    logic [DIV_W-1:0]   div_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    code_t              shift_reg;

    logic               take;
    logic               div_end;
    logic               last_bit;
    logic               bit_done;

    assign take     = (state == IDLE) && code_valid && code_ready;
    assign div_end  = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign last_bit = (bit_cnt == BIT_W'(RESOLUTION - 1));

    // End of a high half, the DAC has just sampled the current bit
    assign bit_done = (state == SHIFT) && div_end && dac_sclk;

    // Half-period divider, free running outside IDLE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (state == IDLE || div_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Data word, MSB leaves first
    always_ff @(posedge clk) begin
        if (take) begin
            shift_reg <= code;
        end else if (bit_done && !last_bit) begin
            shift_reg <= shift_reg << 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            code_ready <= 1'b1;
            busy       <= 1'b0;
            dac_cs_n   <= 1'b1;
            dac_sclk   <= 1'b0;
            dac_din    <= 1'b0;
            dac_ldac_n <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state      <= SELECT;
                        code_ready <= 1'b0;
                        busy       <= 1'b1;
                        dac_cs_n   <= 1'b0;
                        dac_din    <= code[RESOLUTION-1];
                        bit_cnt    <= '0;
                    end else begin
                        code_ready <= 1'b1;
                    end
                end

                // First low half, MSB set up ahead of the first edge
                SELECT: begin
                    if (div_end) begin
                        dac_sclk <= 1'b1;
                        state    <= SHIFT;
                    end
                end

                SHIFT: begin
                    if (bit_done) begin
                        dac_sclk <= 1'b0;
                        if (last_bit) begin
                            dac_cs_n <= 1'b1;
                            dac_din  <= 1'b0;
                            bit_cnt  <= '0;
                            state    <= DESELECT;
                        end else begin
                            dac_din <= shift_reg[RESOLUTION-2];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (div_end) begin
                        dac_sclk <= 1'b1;
                    end
                end

                // Bit counter now counts half periods of the gap
                DESELECT: begin
                    if (div_end) begin
                        if (bit_cnt == BIT_W'(LDAC_GAP_HALVES - 1)) begin
                            dac_ldac_n <= 1'b0;
                            bit_cnt    <= '0;
                            state      <= LOAD;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                LOAD: begin
                    if (div_end) begin
                        if (bit_cnt == BIT_W'(LDAC_WIDTH_HALVES - 1)) begin
                            dac_ldac_n <= 1'b1;
                            busy       <= 1'b0;
                            bit_cnt    <= '0;
                            state      <= IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // LDAC pulse only after the frame has closed
    a_cs_ldac_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(!dac_cs_n && !dac_ldac_n)
    );

    a_sclk_idle_low: assert property (
        @(posedge clk) disable iff (rst)
        dac_cs_n |-> !dac_sclk
    );

endmodule

/* source/dac_types_pkg.sv */
package dac_types_pkg;

    // Width of the audio sample path
    localparam int SAMPLE_BITS = 16;

    // Gain word, unsigned fixed point
    localparam int GAIN_BITS = 8;

    // Fraction bits of gain_t, so 64 is unity
    localparam int GAIN_FRAC_BITS = 6;

    // Signed input sample, two's complement
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // DAC code in offset binary, 0x8000 is midscale
    typedef logic [SAMPLE_BITS-1:0] code_t;

    // Gain with range 0 to just under 4.0
    typedef logic [GAIN_BITS-1:0] gain_t;

endpackage

/* source/pmod_dac_stream.sv */
module pmod_dac_stream
    import dac_types_pkg::*;
#(
    parameter int RESOLUTION = SAMPLE_BITS,
    parameter int FIFO_DEPTH = 8,
    parameter int SCLK_DIV   = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  gain_t   gain,

    // Sample stream in
    input  logic    s_valid,
    input  sample_t s_data,
    output logic    s_ready,
    output logic    busy,

    // PMOD DAC pins
    output logic    dac_cs_n,
    output logic    dac_sclk,
    output logic    dac_din,
    output logic    dac_ldac_n
);

    logic    fifo_valid;
    logic    fifo_ready;
    sample_t fifo_data;

    logic    code_valid;
    logic    code_ready;
    code_t   code;

    // Absorbs bursts while the serial link drains slowly
    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_sample_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (s_valid),
        .in_data    (s_data),
        .in_ready   (s_ready),
        .out_valid  (fifo_valid),
        .out_ready  (fifo_ready),
        .out_data   (fifo_data)
    );

    sample_formatter #(
        .RESOLUTION (RESOLUTION)
    ) i_sample_formatter (
        .clk        (clk),
        .rst        (rst),
        .gain       (gain),
        .in_valid   (fifo_valid),
        .in_data    (fifo_data),
        .in_ready   (fifo_ready),
        .out_valid  (code_valid),
        .out_ready  (code_ready),
        .out_code   (code)
    );

    dac_spi_serializer #(
        .RESOLUTION (RESOLUTION),
        .SCLK_DIV   (SCLK_DIV)
    ) i_dac_spi_serializer (
        .clk        (clk),
        .rst        (rst),
        .code_valid (code_valid),
        .code       (code),
        .code_ready (code_ready),
        .busy       (busy),
        .dac_cs_n   (dac_cs_n),
        .dac_sclk   (dac_sclk),
        .dac_din    (dac_din),
        .dac_ldac_n (dac_ldac_n)
    );

endmodule

/* source/sample_fifo.sv */
module sample_fifo
    import dac_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic    clk,
    input  logic    rst,

    // Producer side
    input  logic    in_valid,
    input  sample_t in_data,
    output logic    in_ready,

    // Consumer side
    output logic    out_valid,
    input  logic    out_ready,
    output sample_t out_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    sample_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // A full buffer still takes a write when the head leaves this cycle
    assign in_ready = !full || out_ready;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Sample storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Full with no read means nothing gets written next cycle
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (full && !rd_en) |=> (full && wr_ptr == $past(wr_ptr))
    );

endmodule

/* source/sample_formatter.sv */
module sample_formatter
    import dac_types_pkg::*;
#(
    parameter int RESOLUTION = 16
) (
    input  logic    clk,
    input  logic    rst,
    input  gain_t   gain,

    // Samples from the FIFO
    input  logic    in_valid,
    input  sample_t in_data,
    output logic    in_ready,

    // Codes toward the serializer
    output logic    out_valid,
    input  logic    out_ready,
    output code_t   out_code
);

    // Room for sample times gain with the gain's sign bit added
    localparam int PROD_W = SAMPLE_BITS + GAIN_BITS + 1;

    localparam logic signed [PROD_W-1:0] SAT_MAX =
        (PROD_W'(1) << (RESOLUTION - 1)) - PROD_W'(1);
    localparam logic signed [PROD_W-1:0] SAT_MIN = ~SAT_MAX;

    localparam code_t CODE_MASK = (code_t'(1) << RESOLUTION) - code_t'(1);
    localparam code_t MIDSCALE  = code_t'(1) << (RESOLUTION - 1);

    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] scaled;
    sample_t                  clamped;
    code_t                    next_code;
    logic                     load;

    always_comb begin
        product = in_data * $signed({1'b0, gain});
        // Arithmetic shift, rounds toward minus infinity
        scaled  = product >>> GAIN_FRAC_BITS;
        if (scaled > SAT_MAX) begin
            clamped = SAT_MAX[SAMPLE_BITS-1:0];
        end else if (scaled < SAT_MIN) begin
            clamped = SAT_MIN[SAMPLE_BITS-1:0];
        end else begin
            clamped = scaled[SAMPLE_BITS-1:0];
        end
        // Offset binary is two's complement with the top bit flipped
        next_code = (code_t'(clamped) & CODE_MASK) ^ MIDSCALE;
    end

    // Stage accepts when empty or when its content leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_code <= next_code;
        end
    end

    a_code_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_code))
    );

endmodule
